//--- hdl/isa_pkg.sv
// instruction encodings for the scalar and matrix opcodes
// decoded operation enums shared by decoder and issue stage
package isa_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        RTYPE    = 7'b0110011,
        ITYPE    = 7'b0010011,
        ITYPE_LW = 7'b0000011,
        STYPE    = 7'b0100011,
        BTYPE    = 7'b1100011,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        LUI      = 7'b0110111,
        HALT     = 7'b1111111,
        LD_M     = 7'b1000111,
        ST_M     = 7'b1010111,
        GEMM_M   = 7'b1110111
    } opcode_t;

    // r-type funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // i-type funct3
    localparam logic [2:0] F3_ADDI      = 3'b000;
    localparam logic [2:0] F3_SLLI      = 3'b001;
    localparam logic [2:0] F3_SLTI      = 3'b010;
    localparam logic [2:0] F3_SLTIU     = 3'b011;
    localparam logic [2:0] F3_XORI      = 3'b100;
    localparam logic [2:0] F3_SRLI_SRAI = 3'b101;
    localparam logic [2:0] F3_ORI       = 3'b110;
    localparam logic [2:0] F3_ANDI      = 3'b111;

    // b-type funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // only word width is supported for lw / sw
    localparam logic [2:0] F3_WORD = 3'b010;

    localparam logic [6:0] F7_SUB_SRA = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BEQ, BNE, BLT, BGE, BLTU, BGEU
    } branch_t;

    typedef enum logic [1:0] {FU_NONE, ALU, LD_ST, BRANCH} fu_scalar_t;

    typedef enum logic [1:0] {FUM_NONE, FUM_LD_ST, GEMM} fu_matrix_t;

    typedef enum logic [1:0] {MEM_NONE, LOAD, STORE} mem_type_t;

    typedef enum logic {U_NONE, U_LUI} u_type_t;

endpackage

//--- hdl/core_types_pkg.sv
// datapath word and register index types
package core_types_pkg;

    // scalar data word
    typedef logic [31:0] word_t;

    // scalar register index, also used for the stride register
    typedef logic [4:0] reg_idx_t;

    // matrix destination register
    typedef logic [3:0] mreg_idx_t;

endpackage

//--- hdl/control_unit_if.sv
// decoder bundle: instruction in, decoded control fields out
`timescale 1ns/100ps

interface control_unit_if;
    import isa_pkg::*;
    import core_types_pkg::*;

    word_t      instr;

    // scalar control
    logic       halt;
    logic       i_flag;
    mem_type_t  s_mem_type;
    logic       reg_write;
    logic       jal;
    logic       jalr;
    u_type_t    u_type;
    alu_op_t    alu_op;
    branch_t    branch_type;
    word_t      imm;
    fu_scalar_t fu_s;

    // matrix control
    reg_idx_t   stride;
    fu_matrix_t fu_m;
    mem_type_t  m_mem_type;
    mreg_idx_t  matrix_rd;

    modport cu (
        input  instr,
        output halt, i_flag, s_mem_type, reg_write, jal, jalr, u_type,
               alu_op, branch_type, imm, stride, fu_s, fu_m, m_mem_type, matrix_rd
    );

    modport issue (
        output instr,
        input  halt, i_flag, s_mem_type, reg_write, jal, jalr, u_type,
               alu_op, branch_type, imm, stride, fu_s, fu_m, m_mem_type, matrix_rd
    );

endinterface

//--- hdl/control_unit.sv
// combinational decoder for rv32i subset plus ld.m, st.m and gemm.m
`timescale 1ns/100ps

module control_unit (
    control_unit_if.cu cu_if
);
    import isa_pkg::*;
    import core_types_pkg::*;

    word_t instr;

    assign instr = cu_if.instr;

    always_comb
    begin
        // everything idle unless the opcode says otherwise
        cu_if.halt        = 1'b0;
        cu_if.i_flag      = 1'b0;
        cu_if.s_mem_type  = MEM_NONE;
        cu_if.reg_write   = 1'b0;
        cu_if.jal         = 1'b0;
        cu_if.jalr        = 1'b0;
        cu_if.u_type      = U_NONE;
        cu_if.alu_op      = ALU_ADD;
        cu_if.branch_type = BR_NONE;
        cu_if.imm         = '0;
        cu_if.stride      = '0;
        cu_if.fu_s        = FU_NONE;
        cu_if.fu_m        = FUM_NONE;
        cu_if.m_mem_type  = MEM_NONE;
        cu_if.matrix_rd   = '0;

        case (opcode_t'(instr[6:0]))
            RTYPE:
            begin
                cu_if.reg_write = 1'b1;
                cu_if.fu_s      = ALU;
                case (instr[14:12])
                    F3_ADD_SUB: cu_if.alu_op = (instr[31:25] == F7_SUB_SRA) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     cu_if.alu_op = ALU_SLL;
                    F3_SLT:     cu_if.alu_op = ALU_SLT;
                    F3_SLTU:    cu_if.alu_op = ALU_SLTU;
                    F3_XOR:     cu_if.alu_op = ALU_XOR;
                    F3_SRL_SRA: cu_if.alu_op = (instr[31:25] == F7_SUB_SRA) ? ALU_SRA : ALU_SRL;
                    F3_OR:      cu_if.alu_op = ALU_OR;
                    F3_AND:     cu_if.alu_op = ALU_AND;
                endcase
            end
            ITYPE:
            begin
                cu_if.reg_write = 1'b1;
                cu_if.i_flag    = 1'b1;
                cu_if.fu_s      = ALU;
                cu_if.imm       = {{20{instr[31]}}, instr[31:20]};
                case (instr[14:12])
                    F3_ADDI:      cu_if.alu_op = ALU_ADD;
                    F3_SLLI:      cu_if.alu_op = ALU_SLL;
                    F3_SLTI:      cu_if.alu_op = ALU_SLT;
                    F3_SLTIU:     cu_if.alu_op = ALU_SLTU;
                    F3_XORI:      cu_if.alu_op = ALU_XOR;
                    F3_SRLI_SRAI: cu_if.alu_op = (instr[31:25] == F7_SUB_SRA) ? ALU_SRA : ALU_SRL;
                    F3_ORI:       cu_if.alu_op = ALU_OR;
                    F3_ANDI:      cu_if.alu_op = ALU_AND;
                endcase
            end
            ITYPE_LW:
            begin
                // other widths decode to nothing
                if (instr[14:12] == F3_WORD)
                begin
                    cu_if.reg_write  = 1'b1;
                    cu_if.i_flag     = 1'b1;
                    cu_if.s_mem_type = LOAD;
                    cu_if.fu_s       = LD_ST;
                    cu_if.imm        = {{20{instr[31]}}, instr[31:20]};
                end
            end
            STYPE:
            begin
                if (instr[14:12] == F3_WORD)
                begin
                    cu_if.i_flag     = 1'b1;
                    cu_if.s_mem_type = STORE;
                    cu_if.fu_s       = LD_ST;
                    cu_if.imm        = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
            end
            BTYPE:
            begin
                cu_if.fu_s = BRANCH;
                cu_if.imm  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
                case (instr[14:12])
                    F3_BEQ:  cu_if.branch_type = BEQ;
                    F3_BNE:  cu_if.branch_type = BNE;
                    F3_BLT:  cu_if.branch_type = BLT;
                    F3_BGE:  cu_if.branch_type = BGE;
                    F3_BLTU: cu_if.branch_type = BLTU;
                    F3_BGEU: cu_if.branch_type = BGEU;
                    // funct3 2 and 3 are reserved
                    default: cu_if.fu_s = FU_NONE;
                endcase
            end
            JAL:
            begin
                cu_if.reg_write = 1'b1;
                cu_if.jal       = 1'b1;
                cu_if.i_flag    = 1'b1;
                cu_if.fu_s      = ALU;
                cu_if.imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
            end
            JALR:
            begin
                cu_if.reg_write = 1'b1;
                cu_if.jalr      = 1'b1;
                cu_if.i_flag    = 1'b1;
                cu_if.fu_s      = ALU;
                cu_if.imm       = {{20{instr[31]}}, instr[31:20]};
            end
            LUI:
            begin
                cu_if.reg_write = 1'b1;
                cu_if.u_type    = U_LUI;
                cu_if.imm       = {instr[31:12], 12'b0};
            end
            HALT:
                cu_if.halt = 1'b1;
            LD_M, ST_M:
            begin
                // stride is a scalar register index, imm is an 11-bit offset
                cu_if.fu_m       = FUM_LD_ST;
                cu_if.m_mem_type = (instr[6:0] == LD_M) ? LOAD : STORE;
                cu_if.imm        = {{21{instr[17]}}, instr[17:7]};
                cu_if.stride     = instr[22:18];
                cu_if.matrix_rd  = instr[31:28];
            end
            GEMM_M:
                cu_if.fu_m = GEMM;
            default:
            begin
                // unknown opcode, leave everything idle
            end
        endcase
    end

endmodule

//--- hdl/scalar_regfile.sv
// scalar register file, two combinational read ports with write-through
`timescale 1ns/100ps

module scalar_regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_en,
    input  core_types_pkg::reg_idx_t wb_rd,
    input  core_types_pkg::word_t    wb_data,
    input  core_types_pkg::reg_idx_t rs1,
    input  core_types_pkg::reg_idx_t rs2,
    output core_types_pkg::word_t    rs1_data,
    output core_types_pkg::word_t    rs2_data
);
    import core_types_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_ok;

    // x0 and indices past the file are not writable
    assign wr_ok = wb_en && (wb_rd != '0) && (int'(wb_rd) < NUM_REGS);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_ok)
        begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write bypasses to the read ports
    assign rs1_data = (rs1 == '0 || int'(rs1) >= NUM_REGS) ? '0 :
                      (wr_ok && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0 || int'(rs2) >= NUM_REGS) ? '0 :
                      (wr_ok && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

//--- hdl/issue_stage.sv
// issue register: operand select, scalar / matrix routing, halt latch
`timescale 1ns/100ps

module issue_stage #(
    parameter int NUM_REGS = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  core_types_pkg::word_t     instr,
    control_unit_if.issue             cu_if,
    input  core_types_pkg::word_t     rs1_data,
    input  core_types_pkg::word_t     rs2_data,
    output core_types_pkg::reg_idx_t  rs1,
    output core_types_pkg::reg_idx_t  rs2,
    output logic                      s_valid,
    output isa_pkg::fu_scalar_t       s_fu,
    output isa_pkg::alu_op_t          s_alu_op,
    output isa_pkg::branch_t          s_branch_type,
    output isa_pkg::mem_type_t        s_mem_type,
    output isa_pkg::u_type_t          s_u_type,
    output logic                      s_reg_write,
    output logic                      s_jal,
    output logic                      s_jalr,
    output core_types_pkg::reg_idx_t  s_rd,
    output core_types_pkg::word_t     s_opa,
    output core_types_pkg::word_t     s_opb,
    output core_types_pkg::word_t     s_imm,
    output logic                      m_valid,
    output isa_pkg::fu_matrix_t       m_fu,
    output isa_pkg::mem_type_t        m_mem_type,
    output core_types_pkg::mreg_idx_t m_rd,
    output core_types_pkg::word_t     m_base,
    output core_types_pkg::word_t     m_stride,
    output core_types_pkg::word_t     m_imm,
    output logic                      halted
);
    import isa_pkg::*;
    import core_types_pkg::*;

    // folds register indices into the implemented file
    localparam reg_idx_t IDX_MASK = reg_idx_t'(NUM_REGS - 1);

    logic issue_en;
    logic to_matrix;
    logic to_scalar;

    assign cu_if.instr = instr;

    // matrix ld / st read the stride register on the second port
    assign rs1 = instr[19:15] & IDX_MASK;
    assign rs2 = ((cu_if.fu_m == FUM_LD_ST) ? cu_if.stride : instr[24:20]) & IDX_MASK;

    assign issue_en  = instr_valid && !halted;
    assign to_matrix = (cu_if.fu_m != FUM_NONE);
    assign to_scalar = (cu_if.fu_s != FU_NONE) || (cu_if.u_type == U_LUI);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            halted        <= 1'b0;
            s_valid       <= 1'b0;
            s_fu          <= FU_NONE;
            s_alu_op      <= ALU_ADD;
            s_branch_type <= BR_NONE;
            s_mem_type    <= MEM_NONE;
            s_u_type      <= U_NONE;
            s_reg_write   <= 1'b0;
            s_jal         <= 1'b0;
            s_jalr        <= 1'b0;
            s_rd          <= '0;
            s_opa         <= '0;
            s_opb         <= '0;
            s_imm         <= '0;
            m_valid       <= 1'b0;
            m_fu          <= FUM_NONE;
            m_mem_type    <= MEM_NONE;
            m_rd          <= '0;
            m_base        <= '0;
            m_stride      <= '0;
            m_imm         <= '0;
        end
        else
        begin
            // valids are single-cycle pulses
            s_valid <= 1'b0;
            m_valid <= 1'b0;
            if (issue_en)
            begin
                if (cu_if.halt)
                begin
                    halted <= 1'b1;
                end
                else if (to_matrix)
                begin
                    m_valid    <= 1'b1;
                    m_fu       <= cu_if.fu_m;
                    m_mem_type <= cu_if.m_mem_type;
                    m_rd       <= cu_if.matrix_rd;
                    m_base     <= rs1_data;
                    m_stride   <= rs2_data;
                    m_imm      <= cu_if.imm;
                end
                else if (to_scalar)
                begin
                    s_valid       <= 1'b1;
                    s_fu          <= cu_if.fu_s;
                    s_alu_op      <= cu_if.alu_op;
                    s_branch_type <= cu_if.branch_type;
                    s_mem_type    <= cu_if.s_mem_type;
                    s_u_type      <= cu_if.u_type;
                    s_reg_write   <= cu_if.reg_write;
                    s_jal         <= cu_if.jal;
                    s_jalr        <= cu_if.jalr;
                    s_rd          <= instr[11:7] & IDX_MASK;
                    s_opa         <= rs1_data;
                    s_opb         <= cu_if.i_flag ? cu_if.imm : rs2_data;
                    s_imm         <= cu_if.imm;
                end
            end
        end
    end

endmodule

//--- hdl/decode_top.sv
// decode and issue top level: decoder, scalar register file, issue stage
`timescale 1ns/100ps

module decode_top #(
    parameter int NUM_REGS = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  core_types_pkg::word_t     instr,
    input  logic                      wb_en,
    input  core_types_pkg::reg_idx_t  wb_rd,
    input  core_types_pkg::word_t     wb_data,
    output logic                      s_valid,
    output isa_pkg::fu_scalar_t       s_fu,
    output isa_pkg::alu_op_t          s_alu_op,
    output isa_pkg::branch_t          s_branch_type,
    output isa_pkg::mem_type_t        s_mem_type,
    output isa_pkg::u_type_t          s_u_type,
    output logic                      s_reg_write,
    output logic                      s_jal,
    output logic                      s_jalr,
    output core_types_pkg::reg_idx_t  s_rd,
    output core_types_pkg::word_t     s_opa,
    output core_types_pkg::word_t     s_opb,
    output core_types_pkg::word_t     s_imm,
    output logic                      m_valid,
    output isa_pkg::fu_matrix_t       m_fu,
    output isa_pkg::mem_type_t        m_mem_type,
    output core_types_pkg::mreg_idx_t m_rd,
    output core_types_pkg::word_t     m_base,
    output core_types_pkg::word_t     m_stride,
    output core_types_pkg::word_t     m_imm,
    output logic                      halted
);
    import core_types_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;

    control_unit_if cu_bus ();

    control_unit u_control_unit (
        .cu_if (cu_bus)
    );

    scalar_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_scalar_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    issue_stage #(
        .NUM_REGS (NUM_REGS)
    ) u_issue_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .cu_if         (cu_bus),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .rs1           (rs1),
        .rs2           (rs2),
        .s_valid       (s_valid),
        .s_fu          (s_fu),
        .s_alu_op      (s_alu_op),
        .s_branch_type (s_branch_type),
        .s_mem_type    (s_mem_type),
        .s_u_type      (s_u_type),
        .s_reg_write   (s_reg_write),
        .s_jal         (s_jal),
        .s_jalr        (s_jalr),
        .s_rd          (s_rd),
        .s_opa         (s_opa),
        .s_opb         (s_opb),
        .s_imm         (s_imm),
        .m_valid       (m_valid),
        .m_fu          (m_fu),
        .m_mem_type    (m_mem_type),
        .m_rd          (m_rd),
        .m_base        (m_base),
        .m_stride      (m_stride),
        .m_imm         (m_imm),
        .halted        (halted)
    );

endmodule

//--- tests/decode_top_tb.sv
// testbench for decode_top, driven from a table of register writes and instructions
`timescale 1ns/100ps

module decode_top_tb;
    import isa_pkg::*;
    import core_types_pkg::*;

    localparam int NUM_REGS   = 32;
    localparam int RST_CYCLES = 8;
    localparam int MAX_CASES  = 64;
    localparam int CASE_WORDS = 5;

    // case kinds in the first column of the table
    localparam logic [3:0] K_WRITE  = 4'h0;
    localparam logic [3:0] K_SCALAR = 4'h1;
    localparam logic [3:0] K_MATRIX = 4'h2;
    localparam logic [3:0] K_HALT   = 4'h4;
    localparam logic [3:0] K_RESET  = 4'h5;

    logic       clk;
    logic       rst_n;
    logic       instr_valid;
    word_t      instr;
    logic       wb_en;
    reg_idx_t   wb_rd;
    word_t      wb_data;
    logic       s_valid;
    fu_scalar_t s_fu;
    alu_op_t    s_alu_op;
    branch_t    s_branch_type;
    mem_type_t  s_mem_type;
    u_type_t    s_u_type;
    logic       s_reg_write;
    logic       s_jal;
    logic       s_jalr;
    reg_idx_t   s_rd;
    word_t      s_opa;
    word_t      s_opb;
    word_t      s_imm;
    logic       m_valid;
    fu_matrix_t m_fu;
    mem_type_t  m_mem_type;
    mreg_idx_t  m_rd;
    word_t      m_base;
    word_t      m_stride;
    word_t      m_imm;
    logic       halted;

    word_t       case_mem [0:MAX_CASES*CASE_WORDS-1];
    word_t       shadow [32];
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          n_cases;
    int          n_resets;
    int          limit_cycles = 0;
    logic        found_end;
    logic        exp_halted;

    // expectation for the instruction issued in the previous cycle
    logic        pending;
    logic [3:0]  pend_kind;
    word_t       pend_instr;
    word_t       pend_ctl;
    word_t       pend_imm;
    word_t       pend_opa;
    word_t       pend_opb;

    decode_top #(
        .NUM_REGS (NUM_REGS)
    ) dut_i (.*);

    always #5 clk = ~clk;

    // right-shift galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_word(output word_t w);
        for (int i = 0; i < 32; i++)
        begin
            w[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic write_reg(input reg_idx_t rd);
        word_t data;
        rand_word(data);
        wb_en   = 1'b1;
        wb_rd   = rd;
        wb_data = data;
        // x0 stays zero
        if (rd != '0)
            shadow[rd] = data;
    endtask

    task automatic check_idle();
        check_value("s_valid", 32'h0, 32'(s_valid));
        check_value("m_valid", 32'h0, 32'(m_valid));
        check_value("halted", 32'h0, 32'(halted));
        check_value("s_fu", 32'h0, 32'(s_fu));
        check_value("s_alu_op", 32'h0, 32'(s_alu_op));
        check_value("s_branch_type", 32'h0, 32'(s_branch_type));
        check_value("s_mem_type", 32'h0, 32'(s_mem_type));
        check_value("s_u_type", 32'h0, 32'(s_u_type));
        check_value("s_reg_write", 32'h0, 32'(s_reg_write));
        check_value("s_jal", 32'h0, 32'(s_jal));
        check_value("s_jalr", 32'h0, 32'(s_jalr));
        check_value("s_rd", 32'h0, 32'(s_rd));
        check_value("s_opa", 32'h0, s_opa);
        check_value("s_opb", 32'h0, s_opb);
        check_value("s_imm", 32'h0, s_imm);
        check_value("m_fu", 32'h0, 32'(m_fu));
        check_value("m_mem_type", 32'h0, 32'(m_mem_type));
        check_value("m_rd", 32'h0, 32'(m_rd));
        check_value("m_base", 32'h0, m_base);
        check_value("m_stride", 32'h0, m_stride);
        check_value("m_imm", 32'h0, m_imm);
    endtask

    task automatic apply_reset();
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        wb_en       = 1'b0;
        exp_halted  = 1'b0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        repeat (RST_CYCLES) @(negedge clk);
        check_idle();
        rst_n = 1'b1;
    endtask

    task automatic check_issue();
        check_value("halted", 32'(exp_halted), 32'(halted));
        check_value("s_valid", 32'(pend_kind == K_SCALAR), 32'(s_valid));
        check_value("m_valid", 32'(pend_kind == K_MATRIX), 32'(m_valid));
        if (pend_kind == K_SCALAR)
        begin
            check_value("s_fu", 32'(pend_ctl[31:28]), 32'(s_fu));
            check_value("s_alu_op", 32'(pend_ctl[27:24]), 32'(s_alu_op));
            check_value("s_branch_type", 32'(pend_ctl[23:20]), 32'(s_branch_type));
            check_value("s_mem_type", 32'(pend_ctl[19:16]), 32'(s_mem_type));
            check_value("s_u_type", 32'(pend_ctl[15:12]), 32'(s_u_type));
            check_value("s_reg_write", 32'(pend_ctl[11:8]), 32'(s_reg_write));
            check_value("s_jal", 32'(pend_ctl[7:4]), 32'(s_jal));
            check_value("s_jalr", 32'(pend_ctl[3:0]), 32'(s_jalr));
            check_value("s_rd", 32'(pend_instr[11:7]), 32'(s_rd));
            check_value("s_opa", pend_opa, s_opa);
            check_value("s_opb", pend_opb, s_opb);
            check_value("s_imm", pend_imm, s_imm);
        end
        else if (pend_kind == K_MATRIX)
        begin
            check_value("m_fu", 32'(pend_ctl[31:28]), 32'(m_fu));
            check_value("m_rd", 32'(pend_ctl[27:24]), 32'(m_rd));
            check_value("m_mem_type", 32'(pend_ctl[19:16]), 32'(m_mem_type));
            check_value("m_base", pend_opa, m_base);
            check_value("m_stride", pend_opb, m_stride);
            check_value("m_imm", pend_imm, m_imm);
        end
    endtask

    task automatic run_case(input int c);
        logic [3:0] kind;
        word_t      w_instr;
        word_t      w_aux;
        reg_idx_t   stride_idx;
        kind    = case_mem[c*CASE_WORDS][3:0];
        w_instr = case_mem[c*CASE_WORDS+1];
        w_aux   = case_mem[c*CASE_WORDS+4];
        @(negedge clk);
        if (pending)
            check_issue();
        pending     = 1'b0;
        instr_valid = 1'b0;
        wb_en       = 1'b0;
        if (kind == K_WRITE)
        begin
            write_reg(w_instr[4:0]);
        end
        else if (kind == K_RESET)
        begin
            apply_reset();
        end
        else
        begin
            // optional write in the same cycle as the strobe
            if (w_aux[4])
                write_reg(w_aux[12:8]);
            instr       = w_instr;
            instr_valid = 1'b1;
            pend_kind   = kind;
            pend_instr  = w_instr;
            pend_ctl    = case_mem[c*CASE_WORDS+2];
            pend_imm    = case_mem[c*CASE_WORDS+3];
            pend_opa    = shadow[w_instr[19:15]];
            stride_idx  = w_aux[1] ? w_instr[22:18] : w_instr[24:20];
            pend_opb    = w_aux[0] ? pend_imm : shadow[stride_idx];
            if (kind == K_HALT)
                exp_halted = 1'b1;
            pending = 1'b1;
        end
    endtask

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        wb_en       = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        errors      = 0;
        checks      = 0;
        pending     = 1'b0;
        exp_halted  = 1'b0;
        lfsr_state  = 32'd76338;
        n_cases     = 0;
        n_resets    = 0;
        found_end   = 1'b0;
        $readmemh("tests/decode_cases.txt", case_mem);
        // the table ends with a line of kind f
        while (!found_end && n_cases < MAX_CASES)
        begin
            if (case_mem[n_cases*CASE_WORDS] == 32'hF)
                found_end = 1'b1;
            else
            begin
                if (case_mem[n_cases*CASE_WORDS][3:0] == K_RESET)
                    n_resets++;
                n_cases++;
            end
        end
        if (!found_end)
        begin
            errors++;
            $display("case table could not be read or has no end line");
        end
        else
        begin
            limit_cycles = n_cases + (n_resets + 1) * (RST_CYCLES + 1) + 20;
            apply_reset();
            for (int c = 0; c < n_cases; c++)
                run_case(c);
            @(negedge clk);
            if (pending)
                check_issue();
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // watchdog sized from the case table
    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- tests/decode_cases.txt
// columns are kind instr ctl imm aux with kind 0 write 1 scalar 2 matrix 3 none 4 halt 5 reset f end
// ctl nibbles fu alu_or_mrd br mem u rw jal jalr and aux bit0 opb_imm bit1 stride_22_18 bit4 wr rd_12_8
0 00000001 00000000 00000000 00000000
0 00000002 00000000 00000000 00000000
0 00000003 00000000 00000000 00000000
0 00000005 00000000 00000000 00000000
0 00000009 00000000 00000000 00000000
1 40208233 11000100 00000000 00000000 // sub x4 x1 x2
1 4021D3B3 14000100 00000000 00000000 // sra x7 x3 x2
1 FFB08413 10000100 FFFFFFFB 00000001 // addi x8 x1 -5
1 01012483 20010100 00000010 00000001 // lw x9 16(x2)
1 FE30AC23 20020000 FFFFFFF8 00000001 // sw x3 -8(x1)
1 FE20C8E3 30300000 FFFFFFF0 00000000 // blt x1 x2 -16
1 001000EF 10000110 00000800 00000001 // jal x1 2048
1 ABCDE537 00001100 ABCDE000 00000000 // lui x10
1 000005B3 10000100 00000000 00000010 // add x11 x0 x0 with x0 write
1 006306B3 10000100 00000000 00000610 // add x13 x6 x6 with x6 write
1 00430067 10000101 00000004 00000001 // jalr x0 4(x6)
2 301491C7 13010000 00000123 00000002 // ld.m m3 base x9 stride x5
2 A0167857 1A020000 FFFFFCF0 00000C12 // st.m m10 base x12 written same cycle
2 00208077 20000000 00000000 00000000 // gemm.m
3 0000000B 00000000 00000000 00000000 // unknown opcode
3 01010083 00000000 00000000 00000000 // lb is not supported
4 0000007F 00000000 00000000 00000000 // halt
3 40208233 00000000 00000000 00000000 // ignored after halt
5 00000000 00000000 00000000 00000000
1 FFB08413 10000100 FFFFFFFB 00000001 // addi after reset reads cleared x1
F 00000000 00000000 00000000 00000000

//--- vlog.f
hdl/isa_pkg.sv
hdl/core_types_pkg.sv
hdl/control_unit_if.sv
hdl/control_unit.sv
hdl/scalar_regfile.sv
hdl/issue_stage.sv
hdl/decode_top.sv
tests/decode_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the decode stage testbench with verilator and run it
verilator --binary -f vlog.f --top-module decode_top_tb -o decode_top_tb_sim \
    && ./obj_dir/decode_top_tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
